/* hw/ssm_params.svh */
`ifndef SSM_PARAMS_SVH
`define SSM_PARAMS_SVH

// one word of compressed stream
`define SSM_WORD_W 128

// 2 * max block size - 1
`define SSM_FUNNEL_W 255

// samples in one block
`define SSM_NUM_PX 16

// component bit depth
`define SSM_BIT_DEPTH 8

`endif

/* hw/stream_pkg.sv */
`default_nettype none

`include "ssm_params.svh"

package stream_pkg;

  // one stream word as it arrives from the source
  // the decode window at the top of the funnel has the same shape
  typedef logic [`SSM_WORD_W-1:0] word_t;

  // funnel shifter contents, msb first
  // valid bits sit at the top, unused bits below are kept zero
  typedef logic [`SSM_FUNNEL_W-1:0] funnel_t;

  // bit count, used for funnel fullness and block size alike
  // 255 is the largest fullness, 128 the largest block
  typedef logic [7:0] bit_count_t;

endpackage

`default_nettype wire

/* hw/mpp_pkg.sv */
`default_nettype none

`include "ssm_params.svh"

package mpp_pkg;

  // midpoint prediction step size, 0 to 7
  // field width is bit depth minus step
  typedef logic [2:0] step_t;

  // one quantized residual
  // the field is zero-extended up to the full bit depth
  typedef logic [`SSM_BIT_DEPTH-1:0] quant_t;

  // all residuals of a block, sample 0 first
  typedef quant_t quant_blk_t [0:`SSM_NUM_PX-1];

endpackage

`default_nettype wire

/* hw/bit_funnel.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ssm_params.svh"

module bit_funnel (
  input  wire                         clk,
  input  wire                         rstn,
  // level, refills only happen while high
  input  wire                         start_dec,
  input  wire stream_pkg::word_t      codec_data,
  // bits taken by the decoder this cycle
  input  wire stream_pkg::bit_count_t consume_bits,
  output logic                        codec_data_rd_en,
  output stream_pkg::word_t           window,
  output logic                        window_vld
);

  localparam stream_pkg::bit_count_t WORD_BITS = stream_pkg::bit_count_t'(`SSM_WORD_W);
  localparam int PAD_W = `SSM_FUNNEL_W - `SSM_WORD_W;

  stream_pkg::funnel_t    shifter;
  stream_pkg::bit_count_t fullness;
  logic                   primed;

  stream_pkg::bit_count_t fullness_rem;
  stream_pkg::bit_count_t fullness_nxt;
  logic                   refill;
  stream_pkg::funnel_t    shifter_left;
  stream_pkg::funnel_t    word_placed;
  stream_pkg::funnel_t    shifter_nxt;

  // fill level once this cycle's block is gone
  assign fullness_rem = fullness - consume_bits;

  // ask for a word when less than one word would be left
  assign refill = start_dec & (fullness_rem < WORD_BITS);
  assign codec_data_rd_en = refill;

  // drop the consumed block off the top
  assign shifter_left = shifter << consume_bits;

  // new word goes right below the remaining bits
  assign word_placed = {codec_data, {PAD_W{1'b0}}} >> fullness_rem;

  always_comb begin
    if (refill) begin
      shifter_nxt  = shifter_left | word_placed;
      fullness_nxt = fullness_rem + WORD_BITS;
    end else begin
      shifter_nxt  = shifter_left;
      fullness_nxt = fullness_rem;
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      shifter  <= '0;
      fullness <= '0;
    end else begin
      shifter  <= shifter_nxt;
      fullness <= fullness_nxt;
    end
  end

  // set by the first word, stays until reset
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      primed <= 1'b0;
    end else if (refill) begin
      primed <= 1'b1;
    end
  end

  assign window_vld = primed;

  // top word of the funnel, zero until the first word is in
  assign window = primed ? shifter[`SSM_FUNNEL_W-1 -: `SSM_WORD_W] : '0;

endmodule

`default_nettype wire

/* hw/mpp_suffix_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ssm_params.svh"

module mpp_suffix_decoder (
  input  wire                    clk,
  input  wire                    rstn,
  input  wire mpp_pkg::step_t    step_size,
  input  wire stream_pkg::word_t window,
  input  wire                    window_vld,
  // size of the block at the top of the window
  output stream_pkg::bit_count_t blk_bits,
  output mpp_pkg::quant_blk_t    quant
);

  localparam int FIELD_W_W = $clog2(`SSM_BIT_DEPTH + 1);
  localparam int OFFSET_W  = $clog2(`SSM_WORD_W);

  mpp_pkg::step_t       step_q;
  logic [FIELD_W_W-1:0] field_w;

  // running bit offset of each sample field from the window msb
  logic [OFFSET_W-1:0]  offset [0:`SSM_NUM_PX-1];

  // step for the block shown in the next cycle
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      step_q <= '0;
    end else begin
      step_q <= step_size;
    end
  end

  // 1 to 8 bits per sample
  assign field_w = FIELD_W_W'(`SSM_BIT_DEPTH) - FIELD_W_W'(step_q);

  // nothing consumed before the funnel is primed
  assign blk_bits = window_vld ? stream_pkg::bit_count_t'(field_w * `SSM_NUM_PX) : '0;

  assign offset[0] = '0;

  genvar i;
  generate
    for (i = 0; i < `SSM_NUM_PX; i++) begin : g_px
      stream_pkg::word_t aligned;

      if (i > 0) begin : g_ofs
        assign offset[i] = offset[i-1] + OFFSET_W'(field_w);
      end

      // field lands in the top bits, msb first
      assign aligned = window << offset[i];

      // low step bits belong to the next field
      assign quant[i] = aligned[`SSM_WORD_W-1 -: `SSM_BIT_DEPTH] >> step_q;
    end
  endgenerate

endmodule

`default_nettype wire

/* hw/ssm_parser.sv */
`timescale 1ns/1ps
`default_nettype none

module ssm_parser (
  input  wire                         clk,
  input  wire                         rstn,
  input  wire                         start_dec,
  input  wire stream_pkg::word_t      codec_data,
  input  wire mpp_pkg::step_t         step_size,
  output wire                         codec_data_rd_en,
  output wire                         blk_vld,
  output wire stream_pkg::bit_count_t blk_bits,
  output wire mpp_pkg::quant_blk_t    quant
);

  // top 128 bits of the funnel
  wire stream_pkg::word_t window;

  bit_funnel u_funnel (
    .clk              (clk),
    .rstn             (rstn),
    .start_dec        (start_dec),
    .codec_data       (codec_data),
    // decoded block size feeds straight back as the shift amount
    .consume_bits     (blk_bits),
    .codec_data_rd_en (codec_data_rd_en),
    .window           (window),
    .window_vld       (blk_vld)
  );

  mpp_suffix_decoder u_mpp (
    .clk        (clk),
    .rstn       (rstn),
    .step_size  (step_size),
    .window     (window),
    .window_vld (blk_vld),
    .blk_bits   (blk_bits),
    .quant      (quant)
  );

endmodule

`default_nettype wire

/* bench/ssm_parser_chk.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ssm_params.svh"

module ssm_parser_chk (
  input wire                         clk,
  input wire                         rstn,
  input wire                         start_dec,
  input wire                         codec_data_rd_en,
  input wire stream_pkg::bit_count_t consume_bits,
  input wire stream_pkg::bit_count_t fullness,
  input wire                         window_vld
);

  localparam stream_pkg::bit_count_t WORD_BITS = stream_pkg::bit_count_t'(`SSM_WORD_W);

  // number of failed checks
  int fail_count = 0;

  // a primed funnel always holds a full window
  a_fill_floor: assert property (
    @(posedge clk) disable iff (!rstn)
    window_vld |-> (fullness >= WORD_BITS)
  ) else begin
    fail_count++;
    $error("funnel fullness dropped below one word");
  end

  // largest block is one word
  a_consume_max: assert property (
    @(posedge clk) disable iff (!rstn)
    consume_bits <= WORD_BITS
  ) else begin
    fail_count++;
    $error("block size larger than one word");
  end

  a_rd_gated: assert property (
    @(posedge clk) disable iff (!rstn)
    codec_data_rd_en |-> start_dec
  ) else begin
    fail_count++;
    $error("read strobe while start_dec is low");
  end

  // valid is sticky until reset
  a_vld_sticky: assert property (
    @(posedge clk) disable iff (!rstn)
    window_vld |=> window_vld
  ) else begin
    fail_count++;
    $error("window valid fell after priming");
  end

endmodule

`default_nettype wire

/* bench/ssm_parser_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ssm_params.svh"

module ssm_parser_tb;

  localparam int CLK_PERIOD = 20;
  localparam int MAX_BLK    = 64;
  localparam int LINE_W     = `SSM_NUM_PX + 1;

  logic                   clk;
  logic                   rstn;
  logic                   start_dec;
  stream_pkg::word_t      codec_data;
  mpp_pkg::step_t         step_size;
  logic                   codec_data_rd_en;
  logic                   blk_vld;
  stream_pkg::bit_count_t blk_bits;
  mpp_pkg::quant_blk_t    quant;

  // step then 16 residuals per block
  logic [7:0] golden_mem [0:MAX_BLK*LINE_W-1];
  int         n_blk = 0;
  logic       loaded = 1'b0;

  stream_pkg::word_t words [$];

  // seen at the falling edge, used by the stimulus at the next rising edge
  logic rd_seen = 1'b0;
  logic vld_seen = 1'b0;

  int   run_cycle = 0;
  int   blk_idx = 0;
  int   words_read = 0;
  int   consumed = 0;
  int   value_errs = 0;
  logic timed_out = 1'b0;

  ssm_parser UUT (
    .clk              (clk),
    .rstn             (rstn),
    .start_dec        (start_dec),
    .codec_data       (codec_data),
    .step_size        (step_size),
    .codec_data_rd_en (codec_data_rd_en),
    .blk_vld          (blk_vld),
    .blk_bits         (blk_bits),
    .quant            (quant)
  );

  bind bit_funnel ssm_parser_chk u_chk (
    .clk              (clk),
    .rstn             (rstn),
    .start_dec        (start_dec),
    .codec_data_rd_en (codec_data_rd_en),
    .consume_bits     (consume_bits),
    .fullness         (fullness),
    .window_vld       (window_vld)
  );

  function automatic mpp_pkg::step_t step_at(input int blk);
    if (blk < n_blk) begin
      return golden_mem[blk*LINE_W][2:0];
    end else begin
      return '0;
    end
  endfunction

  function automatic mpp_pkg::quant_t residual_at(input int blk, input int px);
    return golden_mem[blk*LINE_W + 1 + px];
  endfunction

  // 16 fields of 8 minus step bits each
  function automatic stream_pkg::bit_count_t size_at(input int blk);
    int fw;
    fw = `SSM_BIT_DEPTH - int'(step_at(blk));
    return stream_pkg::bit_count_t'(`SSM_NUM_PX * fw);
  endfunction

  // zeros once the stream has run out
  function automatic stream_pkg::word_t word_at(input int idx);
    if (idx < words.size()) begin
      return words[idx];
    end else begin
      return '0;
    end
  endfunction

  task automatic load_golden();
    for (int i = 0; i < MAX_BLK*LINE_W; i++) begin
      golden_mem[i] = 8'hff;
    end
    $readmemh("bench/ssm_golden.txt", golden_mem);
    // no real step reads as ff
    while (n_blk < MAX_BLK && golden_mem[n_blk*LINE_W] != 8'hff) begin
      n_blk++;
    end
  endtask

  task automatic pack_stream();
    bit                bits [$];
    int                fw;
    mpp_pkg::quant_t   res;
    stream_pkg::word_t w;
    for (int b = 0; b < n_blk; b++) begin
      fw = `SSM_BIT_DEPTH - int'(step_at(b));
      for (int p = 0; p < `SSM_NUM_PX; p++) begin
        res = residual_at(b, p);
        for (int k = fw - 1; k >= 0; k--) begin
          bits.push_back(res[k]);
        end
      end
    end
    while (bits.size() % `SSM_WORD_W != 0) begin
      bits.push_back(1'b0);
    end
    for (int base = 0; base < bits.size(); base += `SSM_WORD_W) begin
      // oldest bit lands in the word msb
      for (int k = 0; k < `SSM_WORD_W; k++) begin
        w[`SSM_WORD_W-1-k] = bits[base+k];
      end
      words.push_back(w);
    end
  endtask

  task automatic check_level(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      value_errs++;
      $display("error %s expected 0x%h got 0x%h", name, exp, act);
    end
  endtask

  task automatic check_bits(input string name, input stream_pkg::bit_count_t exp,
                            input stream_pkg::bit_count_t act);
    if (act !== exp) begin
      value_errs++;
      $display("error %s expected 0x%h got 0x%h", name, exp, act);
    end
  endtask

  task automatic check_quant(input int px, input mpp_pkg::quant_t exp,
                             input mpp_pkg::quant_t act);
    if (act !== exp) begin
      value_errs++;
      $display("error quant[%0d] expected 0x%h got 0x%h in block %0d", px, exp, act, blk_idx);
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (act != exp) begin
      value_errs++;
      $display("error %s expected 0x%h got 0x%h", name, exp, act);
    end
  endtask

  task automatic report_and_finish();
    int others;
    int assert_errs;
    assert_errs = UUT.u_funnel.u_chk.fail_count;
    others = (timed_out ? 1 : 0) + (n_blk == 0 ? 1 : 0);
    $display("%0d value errors, %0d assertion failures, %0d other failures",
             value_errs, assert_errs, others);
    if (value_errs == 0 && assert_errs == 0 && others == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  endtask

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD/2) clk = ~clk;
  end

  initial begin : stimulus
    int widx;
    int sidx;
    rstn       <= 1'b0;
    start_dec  <= 1'b0;
    codec_data <= '0;
    step_size  <= '0;
    load_golden();
    if (n_blk == 0) begin
      $display("no blocks could be read from bench/ssm_golden.txt");
      report_and_finish();
    end else begin
      pack_stream();
      loaded = 1'b1;
      repeat (4) @(posedge clk);
      rstn <= 1'b1;
      repeat (2) @(posedge clk);
      // first word and the step of block 0 go out together
      start_dec  <= 1'b1;
      codec_data <= word_at(0);
      step_size  <= step_at(0);
      widx = 0;
      sidx = 1;
      while (blk_idx < n_blk) begin
        @(posedge clk);
        if (rd_seen) begin
          widx++;
          codec_data <= word_at(widx);
        end
        // step runs one block ahead of the window
        if (rd_seen || vld_seen) begin
          step_size <= step_at(sidx);
          sidx++;
        end
      end
      repeat (2) @(posedge clk);
      report_and_finish();
    end
  end

  always @(negedge clk) begin
    rd_seen  = codec_data_rd_en;
    vld_seen = blk_vld;
    if (!rstn || !start_dec) begin
      check_level("codec_data_rd_en", 1'b0, codec_data_rd_en);
      check_level("blk_vld", 1'b0, blk_vld);
      check_bits("blk_bits", '0, blk_bits);
    end else begin
      run_cycle++;
      if (codec_data_rd_en) begin
        words_read++;
      end
      if (run_cycle == 1) begin
        // priming, word requested but nothing decoded yet
        check_level("codec_data_rd_en", 1'b1, codec_data_rd_en);
        check_level("blk_vld", 1'b0, blk_vld);
        check_bits("blk_bits", '0, blk_bits);
      end else begin
        check_level("blk_vld", 1'b1, blk_vld);
        if (blk_vld && blk_idx < n_blk) begin
          check_bits("blk_bits", size_at(blk_idx), blk_bits);
          for (int p = 0; p < `SSM_NUM_PX; p++) begin
            check_quant(p, residual_at(blk_idx, p), quant[p]);
          end
          consumed += int'(size_at(blk_idx));
          blk_idx++;
          if (blk_idx == n_blk) begin
            // 128 to 255 bits stay in the funnel after a refill
            check_count("words read", (consumed + 255) / 128, words_read);
          end
        end
      end
    end
  end

  initial begin : watchdog
    wait (loaded);
    #((n_blk + 20) * CLK_PERIOD);
    timed_out = 1'b1;
    $display("run timed out at %0t with %0d of %0d blocks checked", $time, blk_idx, n_blk);
    report_and_finish();
  end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+hw
hw/stream_pkg.sv
hw/mpp_pkg.sv
hw/bit_funnel.sv
hw/mpp_suffix_decoder.sv
hw/ssm_parser.sv
bench/ssm_parser_chk.sv
bench/ssm_parser_tb.sv

/* Makefile */
TOP := ssm_parser_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f vlog.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | awk '{ print } /^=== PASS ===$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir

/* bench/ssm_golden.txt */
// per line: step size, then the 16 expected residuals of the block, sample 0 first
// all values in hex, each residual fits in 8 minus step bits
0 00 ff 80 7f 01 fe 55 aa 12 34 56 78 9a bc de f0
0 ff 00 ff 00 c3 3c a5 5a 0f f0 11 ee 22 dd 33 cc
0 80 40 20 10 08 04 02 01 fe fd fb f7 ef df bf 7f
1 7f 00 40 3f 15 2a 55 6a 01 7e 33 4c 66 19 70 0f
2 3f 00 20 1f 15 2a 01 3e 0c 33 2d 12 07 38 24 1b
3 1f 00 10 0f 15 0a 01 1e 03 1c 08 17 19 06 12 0d
4 0f 00 08 07 05 0a 01 0e 03 0c 06 09 02 0d 04 0b
5 07 00 04 03 05 02 01 06 00 07 03 04 06 01 02 05
6 03 00 02 01 03 03 00 00 01 02 03 00 02 01 00 03
7 01 00 01 01 00 00 01 00 01 01 01 00 00 00 01 01
7 00 01 00 01 00 01 00 01 01 00 01 00 01 00 01 00
7 01 01 01 01 01 01 01 01 00 00 00 00 00 00 00 00
7 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 01
7 01 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
7 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01
0 5a a5 3c c3 69 96 0f f0 e1 1e d2 2d b4 4b 78 87
7 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
0 ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff
0 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
0 13 57 9b df 24 68 ac e0 31 75 b9 fd 42 86 ca 0e
6 02 03 01 00 03 02 01 00 00 01 02 03 03 03 00 00
5 06 05 04 03 02 01 00 07 07 00 01 02 03 04 05 06
4 0a 0b 0c 0d 0e 0f 00 01 02 03 04 05 06 07 08 09
3 10 11 12 13 14 15 16 17 18 19 1a 1b 1c 1d 1e 1f
2 01 02 04 08 10 20 3f 3e 3c 38 30 20 00 15 2a 3f
1 40 41 42 43 7c 7d 7e 7f 00 01 02 03 2a 55 3c 63
3 00 01 02 03 04 05 06 07 08 09 0a 0b 0c 0d 0e 0f
1 00 7f 00 7f 55 2a 55 2a 01 02 04 08 10 20 40 7f
5 01 03 05 07 00 02 04 06 07 05 03 01 06 04 02 00
7 01 00 01 00 01 01 00 00 01 01 01 00 00 00 00 01
7 00 01 01 00 01 00 00 01 01 00 00 01 00 01 01 00
2 3f 3f 3f 3f 00 00 00 00 2a 15 2a 15 0b 16 2c 19
4 0f 0e 0d 0c 0b 0a 09 08 07 06 05 04 03 02 01 00
6 00 01 02 03 00 01 02 03 03 02 01 00 03 02 01 00
0 fe dc ba 98 76 54 32 10 01 23 45 67 89 ab cd ef
0 a0 b1 c2 d3 e4 f5 06 17 28 39 4a 5b 6c 7d 8e 9f
5 00 00 07 07 03 04 03 04 01 06 01 06 02 05 02 05
7 01 01 00 00 01 01 00 00 01 01 00 00 01 01 00 00
3 1f 1e 1d 1c 00 01 02 03 0f 10 0a 15 05 1a 11 0e
0 c0 ff ee 00 de ad be ef 0b ad f0 0d 12 34 ab cd
